// ==== Bender.yml ====
package:
  name: com_tracker

sources:
  - hdl/com_pkg.sv
  - hdl/pixel_threshold.sv
  - hdl/frame_accum.sv
  - hdl/centroid_divider.sv
  - hdl/com_tracker_top.sv
  - target: simulation
    files:
      - tb/com_checker.sv
      - tb/tb_com_tracker.sv

// ==== hdl/centroid_divider.sv ====
`timescale 1ns/1ps

module centroid_divider (
  input  logic                         clk_camera,
  input  logic                         sys_rst_pixel,
  input  logic                         tally_i,
  input  logic [com_pkg::SUM_W-1:0]    sum_x_i,
  input  logic [com_pkg::SUM_W-1:0]    sum_y_i,
  input  logic [com_pkg::COUNT_W-1:0]  count_i,
  output logic [com_pkg::HCOUNT_W-1:0] com_x_o,
  output logic [com_pkg::VCOUNT_W-1:0] com_y_o,
  output logic                         com_valid_o,
  output logic                         busy_o
);

  import com_pkg::*;

  // one restoring step on a combined remainder / dividend-quotient pair
  // returns {remainder, quotient} after the step
  function automatic logic [2*SUM_W-1:0] div_step(
    input logic [SUM_W-1:0] rem,
    input logic [SUM_W-1:0] quo,
    input logic [SUM_W-1:0] dvs
  );
    logic [SUM_W-1:0] rem_sh;
    logic [SUM_W-1:0] quo_sh;
    // next dividend bit moves from the quotient register into the remainder
    // remainder stays below the 20-bit divisor so its top bit is always zero
    rem_sh = {rem[SUM_W-2:0], quo[SUM_W-1]};
    quo_sh = {quo[SUM_W-2:0], 1'b0};
    if (rem_sh >= dvs) begin
      rem_sh    = rem_sh - dvs;
      quo_sh[0] = 1'b1;
    end
    return {rem_sh, quo_sh};
  endfunction

  // control
  logic              busy;
  logic [STEP_W-1:0] step_cnt;
  logic              last_step;
  logic              accept;

  // operands, x and y share the divisor
  logic [SUM_W-1:0]   rem_x;
  logic [SUM_W-1:0]   quo_x;
  logic [SUM_W-1:0]   rem_y;
  logic [SUM_W-1:0]   quo_y;
  logic [COUNT_W-1:0] divisor;
  logic [SUM_W-1:0]   divisor_ext;

  // results of this cycle's step
  logic [2*SUM_W-1:0] step_x;
  logic [2*SUM_W-1:0] step_y;

  assign busy_o      = busy;
  assign divisor_ext = {{(SUM_W-COUNT_W){1'b0}}, divisor};

  // a tally is taken only while idle, otherwise it is lost
  assign accept    = tally_i && !busy;
  assign last_step = busy && (step_cnt == STEP_W'(DIV_STEPS - 1));

  assign step_x = div_step(rem_x, quo_x, divisor_ext);
  assign step_y = div_step(rem_y, quo_y, divisor_ext);

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      busy        <= 1'b0;
      step_cnt    <= '0;
      com_valid_o <= 1'b0;
      com_x_o     <= '0;
      com_y_o     <= '0;
    end else begin
      com_valid_o <= 1'b0;
      if (accept) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        // final quotient comes straight out of the last step
        // floored mean fits in the coordinate width
        if (last_step) begin
          busy        <= 1'b0;
          com_valid_o <= 1'b1;
          com_x_o     <= step_x[HCOUNT_W-1:0];
          com_y_o     <= step_y[VCOUNT_W-1:0];
        end
      end
    end
  end

  // datapath, loaded on accept and shifted once per busy cycle
  always_ff @(posedge clk_camera) begin
    if (accept) begin
      rem_x   <= '0;
      rem_y   <= '0;
      quo_x   <= sum_x_i;
      quo_y   <= sum_y_i;
      divisor <= count_i;
    end else if (busy) begin
      rem_x <= step_x[2*SUM_W-1:SUM_W];
      quo_x <= step_x[SUM_W-1:0];
      rem_y <= step_y[2*SUM_W-1:SUM_W];
      quo_y <= step_y[SUM_W-1:0];
    end
  end

endmodule

// ==== hdl/com_pkg.sv ====
package com_pkg;

  // camera raster counts, sized for a 1280x720 frame
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // expanded color channel seen by the threshold
  localparam int CHAN_W = 8;

  // rgb565 field widths
  localparam int RED_W   = 5;
  localparam int GREEN_W = 6;
  localparam int BLUE_W  = 5;
  localparam int PIX_W   = RED_W + GREEN_W + BLUE_W;

  // red gets padded with zero low bits up to a full channel
  localparam int RED_PAD_W = CHAN_W - RED_W;

  // hit count per frame, 1280*720 fits in 20 bits
  localparam int COUNT_W = 20;

  // coordinate sums and divider operand width
  localparam int SUM_W = 32;

  // one quotient bit per iteration
  localparam int DIV_STEPS = SUM_W;
  localparam int STEP_W    = $clog2(DIV_STEPS);

  // field view of a camera word, red in the top bits
  typedef struct packed {
    logic [RED_W-1:0]   red;
    logic [GREEN_W-1:0] green;
    logic [BLUE_W-1:0]  blue;
  } rgb565_t;

  // same 16 bits, either as the raw word or split into fields
  typedef union packed {
    logic [PIX_W-1:0] raw;
    rgb565_t          fields;
  } pixel_t;

endpackage

// ==== hdl/com_tracker_top.sv ====
`timescale 1ns/1ps

module com_tracker_top (
  input  logic                         clk_camera,
  input  logic                         sys_rst_pixel,
  // camera pixel stream
  input  logic                         pix_valid_i,
  input  com_pkg::pixel_t              pixel_i,
  input  logic [com_pkg::HCOUNT_W-1:0] hcount_i,
  input  logic [com_pkg::VCOUNT_W-1:0] vcount_i,
  input  logic                         frame_end_i,
  // red threshold window, held for a whole frame
  input  logic [com_pkg::CHAN_W-1:0]   lower_i,
  input  logic [com_pkg::CHAN_W-1:0]   upper_i,
  // centroid result
  output logic [com_pkg::HCOUNT_W-1:0] com_x_o,
  output logic [com_pkg::VCOUNT_W-1:0] com_y_o,
  output logic                         com_valid_o,
  output logic                         busy_o
);

  import com_pkg::*;

  // threshold stage to accumulator
  logic                hit;
  logic [HCOUNT_W-1:0] hit_hcount;
  logic [VCOUNT_W-1:0] hit_vcount;
  logic                frame_done;

  // accumulator to divider
  logic                tally;
  logic [SUM_W-1:0]    sum_x;
  logic [SUM_W-1:0]    sum_y;
  logic [COUNT_W-1:0]  count;

  // producer, one cycle behind the input stream
  pixel_threshold pixel_threshold_inst (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .pix_valid_i   (pix_valid_i),
    .pixel_i       (pixel_i),
    .hcount_i      (hcount_i),
    .vcount_i      (vcount_i),
    .frame_end_i   (frame_end_i),
    .lower_i       (lower_i),
    .upper_i       (upper_i),
    .hit_o         (hit),
    .hit_hcount_o  (hit_hcount),
    .hit_vcount_o  (hit_vcount),
    .frame_done_o  (frame_done)
  );

  // holds per-frame totals until frame end
  frame_accum frame_accum_inst (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .hit_i         (hit),
    .hit_hcount_i  (hit_hcount),
    .hit_vcount_i  (hit_vcount),
    .frame_done_i  (frame_done),
    .tally_o       (tally),
    .sum_x_o       (sum_x),
    .sum_y_o       (sum_y),
    .count_o       (count)
  );

  // consumer, result 33 cycles after the tally
  centroid_divider centroid_divider_inst (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .tally_i       (tally),
    .sum_x_i       (sum_x),
    .sum_y_i       (sum_y),
    .count_i       (count),
    .com_x_o       (com_x_o),
    .com_y_o       (com_y_o),
    .com_valid_o   (com_valid_o),
    .busy_o        (busy_o)
  );

endmodule

// ==== hdl/frame_accum.sv ====
`timescale 1ns/1ps

module frame_accum (
  input  logic                         clk_camera,
  input  logic                         sys_rst_pixel,
  input  logic                         hit_i,
  input  logic [com_pkg::HCOUNT_W-1:0] hit_hcount_i,
  input  logic [com_pkg::VCOUNT_W-1:0] hit_vcount_i,
  input  logic                         frame_done_i,
  output logic                         tally_o,
  output logic [com_pkg::SUM_W-1:0]    sum_x_o,
  output logic [com_pkg::SUM_W-1:0]    sum_y_o,
  output logic [com_pkg::COUNT_W-1:0]  count_o
);

  import com_pkg::*;

  // running totals for the frame in progress
  logic [SUM_W-1:0]   acc_x;
  logic [SUM_W-1:0]   acc_y;
  logic [COUNT_W-1:0] acc_cnt;

  // totals including this cycle's hit, if any
  logic [SUM_W-1:0]   next_x;
  logic [SUM_W-1:0]   next_y;
  logic [COUNT_W-1:0] next_cnt;

  // coordinates zero-extended to sum width
  logic [SUM_W-1:0]   hit_x_ext;
  logic [SUM_W-1:0]   hit_y_ext;

  assign hit_x_ext = {{(SUM_W-HCOUNT_W){1'b0}}, hit_hcount_i};
  assign hit_y_ext = {{(SUM_W-VCOUNT_W){1'b0}}, hit_vcount_i};

  // a hit that lands with frame_done still belongs to the closing frame
  always_comb begin
    next_x   = acc_x;
    next_y   = acc_y;
    next_cnt = acc_cnt;
    if (hit_i) begin
      next_x   = acc_x + hit_x_ext;
      next_y   = acc_y + hit_y_ext;
      next_cnt = acc_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      acc_x   <= '0;
      acc_y   <= '0;
      acc_cnt <= '0;
      tally_o <= 1'b0;
      sum_x_o <= '0;
      sum_y_o <= '0;
      count_o <= '0;
    end else begin
      // one-cycle strobe by default
      tally_o <= 1'b0;
      if (frame_done_i) begin
        // empty frame hands nothing on, divider would see a zero divisor
        if (next_cnt != '0) begin
          tally_o <= 1'b1;
          sum_x_o <= next_x;
          sum_y_o <= next_y;
          count_o <= next_cnt;
        end
        // next frame always starts from zero
        acc_x   <= '0;
        acc_y   <= '0;
        acc_cnt <= '0;
      end else begin
        acc_x   <= next_x;
        acc_y   <= next_y;
        acc_cnt <= next_cnt;
      end
    end
  end

endmodule

// ==== hdl/pixel_threshold.sv ====
`timescale 1ns/1ps

module pixel_threshold (
  input  logic                         clk_camera,
  input  logic                         sys_rst_pixel,
  input  logic                         pix_valid_i,
  input  com_pkg::pixel_t              pixel_i,
  input  logic [com_pkg::HCOUNT_W-1:0] hcount_i,
  input  logic [com_pkg::VCOUNT_W-1:0] vcount_i,
  input  logic                         frame_end_i,
  input  logic [com_pkg::CHAN_W-1:0]   lower_i,
  input  logic [com_pkg::CHAN_W-1:0]   upper_i,
  output logic                         hit_o,
  output logic [com_pkg::HCOUNT_W-1:0] hit_hcount_o,
  output logic [com_pkg::VCOUNT_W-1:0] hit_vcount_o,
  output logic                         frame_done_o
);

  import com_pkg::*;

  // red field expanded to a full 8-bit channel
  logic [CHAN_W-1:0] red_chan;
  // pixel falls inside the window, bounds inclusive
  logic              in_range;

  // 5-bit red sits in the top of the channel, low bits zero
  assign red_chan = {pixel_i.fields.red, {RED_PAD_W{1'b0}}};

  // lower above upper gives an empty window and so no hits
  assign in_range = (red_chan >= lower_i) && (red_chan <= upper_i);

  // hit strobe and frame end share one register stage
  // so the frame end never overtakes the last pixel
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      hit_o        <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      hit_o        <= pix_valid_i && in_range;
      frame_done_o <= frame_end_i;
    end
  end

  // coordinates travel alongside the hit strobe
  // only meaningful when hit_o is high
  always_ff @(posedge clk_camera) begin
    if (pix_valid_i) begin
      hit_hcount_o <= hcount_i;
      hit_vcount_o <= vcount_i;
    end
  end

endmodule

// ==== list.f ====
hdl/com_pkg.sv
hdl/pixel_threshold.sv
hdl/frame_accum.sv
hdl/centroid_divider.sv
hdl/com_tracker_top.sv
tb/com_checker.sv
tb/tb_com_tracker.sv

// ==== tb/com_checker.sv ====
`timescale 1ns/1ps

module com_checker (
  input logic clk_camera,
  input logic sys_rst_pixel,
  input logic tally_i,
  input logic busy_o,
  input logic com_valid_o
);

  // result strobe is a single-cycle pulse
  property p_valid_single;
    @(posedge clk_camera) disable iff (sys_rst_pixel)
      com_valid_o |=> !com_valid_o;
  endproperty

  // reset clears the strobe by the next edge
  property p_valid_reset;
    @(posedge clk_camera) sys_rst_pixel |=> !com_valid_o;
  endproperty

  // frames are spaced so a tally never meets a busy divider
  property p_tally_idle;
    @(posedge clk_camera) disable iff (sys_rst_pixel)
      !(tally_i && busy_o);
  endproperty

  a_valid_single: assert property (p_valid_single)
    else $error("com_valid_o high for two cycles in a row");
  a_valid_reset: assert property (p_valid_reset)
    else $error("com_valid_o high during reset");
  a_tally_idle: assert property (p_tally_idle)
    else $error("tally_i asserted while divider busy");

endmodule

// attach to every divider instance
bind centroid_divider com_checker com_checker_inst (
  .clk_camera    (clk_camera),
  .sys_rst_pixel (sys_rst_pixel),
  .tally_i       (tally_i),
  .busy_o        (busy_o),
  .com_valid_o   (com_valid_o)
);

// ==== tb/tb_com_tracker.sv ====
`timescale 1ns/1ps

module tb_com_tracker;

  import com_pkg::*;

  localparam int FRAME_W = 40;
  localparam int FRAME_H = 30;
  // cycles from frame end sampled to com_valid_o
  localparam int LATENCY     = 35;
  localparam int RESULT_WAIT = 60;
  localparam int DRAIN_WAIT  = 200;
  localparam int IDLE_GAP    = 40;
  // frame styles
  localparam int RANDOM = 0;
  localparam int FULL   = 1;
  localparam int SPOT   = 2;
  localparam int SPOT_X = 23;
  localparam int SPOT_Y = 11;

  logic                clk_camera;
  logic                sys_rst_pixel;
  logic                pix_valid_i;
  pixel_t              pixel_i;
  logic [HCOUNT_W-1:0] hcount_i;
  logic [VCOUNT_W-1:0] vcount_i;
  logic                frame_end_i;
  logic [CHAN_W-1:0]   lower_i;
  logic [CHAN_W-1:0]   upper_i;
  logic [HCOUNT_W-1:0] com_x_o;
  logic [VCOUNT_W-1:0] com_y_o;
  logic                com_valid_o;
  logic                busy_o;

  logic [15:0] lfsr_state;
  int          cycle_cnt = 0;

  // valid pixels of the frame being sent
  logic [RED_W-1:0]    px_red[$];
  logic [HCOUNT_W-1:0] px_h[$];
  logic [VCOUNT_W-1:0] px_v[$];

  // one entry per frame end still awaiting its result
  string               rec_name[$];
  bit                  rec_expect[$];
  logic [HCOUNT_W-1:0] rec_x[$];
  logic [VCOUNT_W-1:0] rec_y[$];
  int                  rec_cycle[$];

  // centroid the outputs should be holding
  logic [HCOUNT_W-1:0] held_x;
  logic [VCOUNT_W-1:0] held_y;

  int value_errors   = 0;
  int timing_errors  = 0;
  int strobe_errors  = 0;
  int timeout_errors = 0;

  com_tracker_top com_tracker_top_inst (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .pix_valid_i   (pix_valid_i),
    .pixel_i       (pixel_i),
    .hcount_i      (hcount_i),
    .vcount_i      (vcount_i),
    .frame_end_i   (frame_end_i),
    .lower_i       (lower_i),
    .upper_i       (upper_i),
    .com_x_o       (com_x_o),
    .com_y_o       (com_y_o),
    .com_valid_o   (com_valid_o),
    .busy_o        (busy_o)
  );

  initial clk_camera = 1'b0;
  always #2 clk_camera = ~clk_camera;

  // posedge count read only on falling edges
  always @(posedge clk_camera) cycle_cnt <= cycle_cnt + 1;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // floored mean of hit coordinates or 0 when nothing hit
  function automatic bit ref_centroid(input logic [CHAN_W-1:0] lo,
                                      input logic [CHAN_W-1:0] hi,
                                      output logic [HCOUNT_W-1:0] ex,
                                      output logic [VCOUNT_W-1:0] ey);
    longint sx;
    longint sy;
    longint n;
    int     chan;
    sx = 0;
    sy = 0;
    n  = 0;
    ex = '0;
    ey = '0;
    foreach (px_red[i]) begin
      // 5-bit red scaled to an 8-bit channel
      chan = int'(px_red[i]) * 8;
      if (chan >= int'(lo) && chan <= int'(hi)) begin
        sx += px_h[i];
        sy += px_v[i];
        n++;
      end
    end
    if (n == 0) return 1'b0;
    ex = HCOUNT_W'(sx / n);
    ey = VCOUNT_W'(sy / n);
    return 1'b1;
  endfunction

  task automatic check_com_x(input string name, input logic [HCOUNT_W-1:0] exp_v,
                             input logic [HCOUNT_W-1:0] act_v);
    if (act_v !== exp_v) begin
      value_errors++;
      $display("** Error [%s] com_x_o expected %0d, actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic check_com_y(input string name, input logic [VCOUNT_W-1:0] exp_v,
                             input logic [VCOUNT_W-1:0] act_v);
    if (act_v !== exp_v) begin
      value_errors++;
      $display("** Error [%s] com_y_o expected %0d, actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic check_busy(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      strobe_errors++;
      $display("** Error [%s] busy_o expected %0d, actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic check_latency(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
      timing_errors++;
      $display("** Error [%s] latency expected %0d, actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic pop_record();
    void'(rec_name.pop_front());
    void'(rec_expect.pop_front());
    void'(rec_x.pop_front());
    void'(rec_y.pop_front());
    void'(rec_cycle.pop_front());
  endtask

  // sends one frame, queues its expected result, then lets the divider drain
  task automatic run_frame(input string name, input int mode,
                           input logic [CHAN_W-1:0] lo, input logic [CHAN_W-1:0] hi);
    logic [RED_W-1:0]    red;
    logic [HCOUNT_W-1:0] ex;
    logic [VCOUNT_W-1:0] ey;
    bit                  has;
    int                  waited;
    px_red.delete();
    px_h.delete();
    px_v.delete();
    @(negedge clk_camera);
    lower_i = lo;
    upper_i = hi;
    for (int y = 0; y < FRAME_H; y++) begin
      for (int x = 0; x < FRAME_W; x++) begin
        // random frames get idle gaps carrying junk data
        if (mode == RANDOM && rand_bits(2) == 0) begin
          pix_valid_i = 1'b0;
          pixel_i.raw = PIX_W'(rand_bits(PIX_W));
          @(negedge clk_camera);
        end
        red = RED_W'(rand_bits(RED_W));
        if (mode == SPOT)
          red = (x == SPOT_X && y == SPOT_Y) ? 5'd31 : RED_W'(rand_bits(RED_W) % 31);
        // rgb565 puts red in the top five bits
        pixel_i.raw = {red, (PIX_W-RED_W)'(rand_bits(PIX_W - RED_W))};
        pix_valid_i = 1'b1;
        hcount_i    = HCOUNT_W'(x);
        vcount_i    = VCOUNT_W'(y);
        px_red.push_back(red);
        px_h.push_back(hcount_i);
        px_v.push_back(vcount_i);
        @(negedge clk_camera);
      end
    end
    pix_valid_i = 1'b0;
    frame_end_i = 1'b1;
    has = ref_centroid(lo, hi, ex, ey);
    if (mode == FULL) begin
      // every pixel hits so the centroid is the geometric center
      ex = HCOUNT_W'((FRAME_W - 1) / 2);
      ey = VCOUNT_W'((FRAME_H - 1) / 2);
    end else if (mode == SPOT) begin
      ex = HCOUNT_W'(SPOT_X);
      ey = VCOUNT_W'(SPOT_Y);
    end
    if (has) begin
      held_x = ex;
      held_y = ey;
    end
    rec_name.push_back(name);
    rec_expect.push_back(has);
    rec_x.push_back(held_x);
    rec_y.push_back(held_y);
    rec_cycle.push_back(cycle_cnt);
    @(negedge clk_camera);
    frame_end_i = 1'b0;
    repeat (IDLE_GAP) @(negedge clk_camera);
    waited = 0;
    while (rec_name.size() != 0 && waited < DRAIN_WAIT) begin
      @(negedge clk_camera);
      waited++;
    end
    if (rec_name.size() != 0) begin
      timeout_errors++;
      $display("timeout: result of frame %s was never settled", name);
    end
  endtask

  // random window ordered so the frame usually has hits
  task automatic run_random(input string name);
    logic [CHAN_W-1:0] a;
    logic [CHAN_W-1:0] b;
    a = CHAN_W'(rand_bits(CHAN_W));
    b = CHAN_W'(rand_bits(CHAN_W));
    if (a > b) run_frame(name, RANDOM, b, a);
    else run_frame(name, RANDOM, a, b);
  endtask

  // matches each com_valid_o pulse to the oldest outstanding frame
  initial begin : compare_results
    int   age;
    logic busy_exp;
    forever begin
      @(negedge clk_camera);
      if (rec_name.size() == 0) begin
        // nothing pending so the divider sits idle
        check_busy("idle", 1'b0, busy_o);
        if (com_valid_o === 1'b1) begin
          strobe_errors++;
          $display("com_valid_o pulsed at cycle %0d with no frame pending", cycle_cnt);
        end
      end else begin
        age = cycle_cnt - rec_cycle[0];
        // divider runs for the DIV_STEPS cycles that end in the result strobe
        busy_exp = rec_expect[0] && age >= LATENCY - DIV_STEPS && age < LATENCY;
        check_busy(rec_name[0], busy_exp, busy_o);
        if (com_valid_o === 1'b1 && rec_expect[0]) begin
          check_latency(rec_name[0], LATENCY, age);
          check_com_x(rec_name[0], rec_x[0], com_x_o);
          check_com_y(rec_name[0], rec_y[0], com_y_o);
          pop_record();
        end else if (com_valid_o === 1'b1) begin
          strobe_errors++;
          $display("com_valid_o pulsed for frame %s, which has no hits", rec_name[0]);
          pop_record();
        end else if (age >= RESULT_WAIT) begin
          if (rec_expect[0]) begin
            timeout_errors++;
            $display("no com_valid_o within %0d cycles for frame %s", RESULT_WAIT,
                     rec_name[0]);
          end else begin
            // empty frame leaves the previous centroid in place
            check_com_x(rec_name[0], rec_x[0], com_x_o);
            check_com_y(rec_name[0], rec_y[0], com_y_o);
          end
          pop_record();
        end
      end
    end
  end

  initial begin : stimulus
    lfsr_state    = 16'd84;
    sys_rst_pixel = 1'b1;
    pix_valid_i   = 1'b0;
    pixel_i       = '0;
    hcount_i      = '0;
    vcount_i      = '0;
    frame_end_i   = 1'b0;
    lower_i       = '0;
    upper_i       = '1;
    held_x        = '0;
    held_y        = '0;
    repeat (16) @(negedge clk_camera);
    sys_rst_pixel = 1'b0;
    // quiet outputs until the first frame ends
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_camera);
      check_com_x("after_reset", '0, com_x_o);
      check_com_y("after_reset", '0, com_y_o);
      if (com_valid_o !== 1'b0 || busy_o !== 1'b0) begin
        strobe_errors++;
        $display("com_valid_o or busy_o not low after reset");
      end
    end
    for (int i = 0; i < 3; i++) run_random($sformatf("random_%0d", i));
    run_frame("no_hits", RANDOM, 8'd200, 8'd100);
    run_frame("single_hit", SPOT, 8'd248, 8'd248);
    run_frame("full_window", FULL, 8'd0, 8'd255);
    // back-to-back frames after the full window
    for (int i = 3; i < 6; i++) run_random($sformatf("random_%0d", i));
    $display("errors: value %0d, timing %0d, strobe %0d, timeout %0d",
             value_errors, timing_errors, strobe_errors, timeout_errors);
    if (value_errors + timing_errors + strobe_errors + timeout_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
